// ==== include/pcw_kbd_config.svh ====
// Shared constants for the PCW keyboard, joystick and keymouse interface
// Included by the package and by every module that needs geometry,
// PS/2 field positions, decoded scancodes, row numbers or mouse scaling
`ifndef PCW_KBD_CONFIG_SVH
`define PCW_KBD_CONFIG_SVH

// Matrix geometry
`define PCW_ROWS        16      // Rows addressed by the CPU
`define PCW_ROW_BITS    8       // Bits per row
`define PCW_ADDR_W      4       // Row address width

// PS/2 event word fields, scancode sits in [7:0]
`define PS2_TOGGLE_BIT  10      // Flips on every event
`define PS2_PRESSED_BIT 9       // 1 on make, 0 on break
`define PS2_EXT_BIT     8       // Code was preceded by 0xE0

// Scancodes that drive shift and lock state
`define SC_LSHIFT       8'h12
`define SC_RSHIFT       8'h59
`define SC_CAPS         8'h58

// Special rows
`define ROW_JOY1        4'd9    // Joystick 1
`define ROW_JOY2        4'd11   // Joystick 2 or mouse X
`define ROW_FLAGS_D     4'd13   // Link 2 and caps-lock flags
`define ROW_FLAGS_E     4'd14   // Link 3 and link 1 flags
`define ROW_FLAGS_F     4'd15   // Transmit and update flags

// Keymouse scaling
`define MOUSE_SHIFT     3       // Deltas divided by 8
`define MOUSE_POS_W     7       // Wrapping position width

`endif

// ==== rtl/pcw_kbd_pkg.sv ====
// Types shared across the PCW keyboard design
// Import with a wildcard in the module header where a type is needed
`include "pcw_kbd_config.svh"

package pcw_kbd_pkg;

	typedef logic [`PCW_ROW_BITS-1:0] matrix_row_t;         // One matrix row
	typedef matrix_row_t [`PCW_ROWS-1:0] key_matrix_t;      // Whole matrix or a mask of it

	// Row 11 is joystick 2 or the mouse X readout, depending on keymouse
	typedef union packed {
		struct packed {
			logic [1:0] unused;                             // Always zero
			logic       fire2;
			logic       fire1;
			logic       right;
			logic       left;
			logic       down;
			logic       up;
		} joy;
		struct packed {
			logic                    middle;                // Middle button
			logic [`MOUSE_POS_W-1:0] x_pos;                 // Tracked X
		} mouse;
	} joy_mouse_row_u;

endpackage

// ==== rtl/key_event_ctrl.sv ====
// PS/2 event capture and modifier state
// Watches the toggle bit of the host key word, latches the event fields and
// pulses strobe for one cycle per event. Also owns shift and caps-lock state
`timescale 1ns/10ps
`include "pcw_kbd_config.svh"

module key_event_ctrl (
	input  logic        clk_sys,
	input  logic        reset,
	input  logic [10:0] ps2_key,        // Host key word
	output logic        strobe,         // One cycle per captured event
	output logic        pressed,
	output logic        extended,
	output logic [7:0]  code,
	output logic        shift_state,    // Either shift or caps lock
	output logic        capslock
);

	logic prev_toggle;                  // Toggle bit from previous edge
	logic shifted;                      // A shift key is down
	logic new_event;

	assign new_event   = ps2_key[`PS2_TOGGLE_BIT] != prev_toggle;
	assign shift_state = shifted | capslock;

	always_ff @(posedge clk_sys) begin
		prev_toggle <= ps2_key[`PS2_TOGGLE_BIT];    // Sampled on every edge
		if (reset) begin
			strobe   <= 1'b0;
			pressed  <= 1'b0;
			extended <= 1'b0;
			code     <= 8'h00;
			shifted  <= 1'b0;
			capslock <= 1'b0;
		end else begin
			strobe <= new_event;
			if (new_event) begin
				pressed  <= ps2_key[`PS2_PRESSED_BIT];
				extended <= ps2_key[`PS2_EXT_BIT];
				code     <= ps2_key[7:0];
			end
			// Modifiers move with the matrix write
			if (strobe) begin
				if (code == `SC_LSHIFT && !extended)
					shifted <= pressed;                 // E0 12 is print screen
				if (code == `SC_RSHIFT)
					shifted <= pressed;
				if (code == `SC_CAPS && pressed)
					capslock <= ~capslock;              // Release leaves it alone
			end
		end
	end

	// Strobe stays low after reset release unless the host toggles right then
	a_no_strobe_after_reset: assert property (@(posedge clk_sys)
		$fell(reset) && $stable(ps2_key[`PS2_TOGGLE_BIT]) |=> !strobe);

endmodule

// ==== rtl/scancode_mapper.sv ====
// PS/2 scancode to PCW matrix translation
// Purely combinational. hit_mask marks every matrix bit an event touches,
// set_mask the bits that take the pressed value. Extended codes and the
// comma and period keys select one of two targets and clear the other
`timescale 1ns/10ps
`include "pcw_kbd_config.svh"

module scancode_mapper import pcw_kbd_pkg::*; (
	input  logic [7:0]  code,
	input  logic        extended,
	input  logic        shift_state,
	output key_matrix_t hit_mask,
	output key_matrix_t set_mask
);

	// One target that takes the pressed value when v is set
	function automatic void single_key(inout key_matrix_t h, inout key_matrix_t s,
			input int r, input int b, input logic v = 1'b1);
		h[r][b] = 1'b1;
		s[r][b] = v;
	endfunction

	// Two targets where sel picks the second one
	function automatic void dual_key(inout key_matrix_t h, inout key_matrix_t s,
			input int r0, input int b0, input int r1, input int b1, input logic sel);
		h[r0][b0] = 1'b1;
		h[r1][b1] = 1'b1;
		s[r0][b0] = ~sel;
		s[r1][b1] = sel;
	endfunction

	always_comb begin
		hit_mask = '0;
		set_mask = '0;
		case (code)
			8'h12: dual_key(hit_mask, set_mask, 2, 5, 1, 1, extended);  // Left shift, PrtScr -> PTR
			8'h59: single_key(hit_mask, set_mask, 2, 5);      // Right shift
			8'h11: single_key(hit_mask, set_mask, 10, 7);     // Alt
			8'h14: single_key(hit_mask, set_mask, 10, 1);     // Ctrl -> Extra
			8'h05: single_key(hit_mask, set_mask, 0, 2);      // F1 -> F1/F2
			8'h06: single_key(hit_mask, set_mask, 0, 2);      // F2 -> F1/F2
			8'h04: single_key(hit_mask, set_mask, 0, 0);      // F3 -> F3/F4
			8'h0c: single_key(hit_mask, set_mask, 0, 0);      // F4 -> F3/F4
			8'h03: single_key(hit_mask, set_mask, 10, 0);     // F5 -> F5/F6
			8'h0b: single_key(hit_mask, set_mask, 10, 0);     // F6 -> F5/F6
			8'h83: single_key(hit_mask, set_mask, 10, 4);     // F7 -> F7/F8
			8'h0a: single_key(hit_mask, set_mask, 10, 4);     // F8 -> F7/F8
			8'h1c: single_key(hit_mask, set_mask, 8, 5);      // A
			8'h32: single_key(hit_mask, set_mask, 6, 6);      // B
			8'h21: single_key(hit_mask, set_mask, 7, 6);      // C
			8'h23: single_key(hit_mask, set_mask, 7, 5);      // D
			8'h24: single_key(hit_mask, set_mask, 7, 2);      // E
			8'h2b: single_key(hit_mask, set_mask, 6, 5);      // F
			8'h34: single_key(hit_mask, set_mask, 6, 4);      // G
			8'h33: single_key(hit_mask, set_mask, 5, 4);      // H
			8'h43: single_key(hit_mask, set_mask, 4, 3);      // I
			8'h3b: single_key(hit_mask, set_mask, 5, 5);      // J
			8'h42: single_key(hit_mask, set_mask, 4, 5);      // K
			8'h4b: single_key(hit_mask, set_mask, 4, 4);      // L
			8'h3a: single_key(hit_mask, set_mask, 4, 6);      // M
			8'h31: single_key(hit_mask, set_mask, 5, 6);      // N
			8'h44: single_key(hit_mask, set_mask, 4, 2);      // O
			8'h4d: single_key(hit_mask, set_mask, 3, 3);      // P
			8'h15: single_key(hit_mask, set_mask, 8, 3);      // Q
			8'h2d: single_key(hit_mask, set_mask, 6, 2);      // R
			8'h1b: single_key(hit_mask, set_mask, 7, 4);      // S
			8'h2c: single_key(hit_mask, set_mask, 6, 3);      // T
			8'h3c: single_key(hit_mask, set_mask, 5, 2);      // U
			8'h2a: single_key(hit_mask, set_mask, 6, 7);      // V
			8'h1d: single_key(hit_mask, set_mask, 7, 3);      // W
			8'h22: single_key(hit_mask, set_mask, 7, 7);      // X
			8'h35: single_key(hit_mask, set_mask, 5, 3);      // Y
			8'h1a: single_key(hit_mask, set_mask, 8, 7);      // Z
			8'h16: single_key(hit_mask, set_mask, 8, 0);      // 1
			8'h1e: single_key(hit_mask, set_mask, 8, 1);      // 2
			8'h26: single_key(hit_mask, set_mask, 7, 1);      // 3
			8'h25: single_key(hit_mask, set_mask, 7, 0);      // 4
			8'h2e: single_key(hit_mask, set_mask, 6, 1);      // 5
			8'h36: single_key(hit_mask, set_mask, 6, 0);      // 6
			8'h3d: single_key(hit_mask, set_mask, 5, 1);      // 7
			8'h3e: single_key(hit_mask, set_mask, 5, 0);      // 8
			8'h46: single_key(hit_mask, set_mask, 4, 1);      // 9
			8'h45: single_key(hit_mask, set_mask, 4, 0);      // 0
			8'h41: dual_key(hit_mask, set_mask, 4, 7, 3, 4, shift_state);   // Comma or <
			8'h49: dual_key(hit_mask, set_mask, 3, 7, 2, 3, shift_state);   // Period or >
			8'h0d: single_key(hit_mask, set_mask, 8, 4);      // Tab
			8'h76: single_key(hit_mask, set_mask, 1, 0);      // Esc -> Exit
			8'h29: single_key(hit_mask, set_mask, 5, 7);      // Space
			8'h70: dual_key(hit_mask, set_mask, 0, 1, 1, 2, extended);  // KP0, Ins -> Cut
			8'h69: dual_key(hit_mask, set_mask, 1, 7, 10, 2, extended); // KP1, End -> Cancel
			8'h72: dual_key(hit_mask, set_mask, 0, 7, 10, 6, extended); // KP2, Down -> KP.
			8'h7a: single_key(hit_mask, set_mask, 0, 6);      // KP3
			8'h6b: dual_key(hit_mask, set_mask, 1, 5, 1, 7, extended);  // KP4, Left -> KP1
			8'h73: single_key(hit_mask, set_mask, 1, 6);      // KP5
			8'h74: dual_key(hit_mask, set_mask, 0, 5, 0, 6, extended);  // KP6, Right -> KP3
			8'h6c: single_key(hit_mask, set_mask, 2, 4);      // KP7
			8'h75: dual_key(hit_mask, set_mask, 1, 4, 1, 6, extended);  // KP8, Up -> KP5
			8'h7d: dual_key(hit_mask, set_mask, 0, 4, 0, 3, extended);  // KP9, PgUp -> Paste
			8'h71: dual_key(hit_mask, set_mask, 10, 6, 2, 0, extended); // KP., Del -> Del right
			8'h5a: dual_key(hit_mask, set_mask, 2, 2, 10, 5, extended); // Return, KP Enter
			8'h79: single_key(hit_mask, set_mask, 2, 7);      // KP +
			8'h7b: single_key(hit_mask, set_mask, 10, 3);     // KP -
			8'h01: single_key(hit_mask, set_mask, 2, 7);      // F9 doubles as KP +
			8'h09: single_key(hit_mask, set_mask, 10, 3);     // F10 doubles as KP -
			8'h66: single_key(hit_mask, set_mask, 9, 7);      // Backspace -> Del left
			8'h6e: single_key(hit_mask, set_mask, 1, 3, extended);  // Home -> Copy on E0 only
			8'h58: single_key(hit_mask, set_mask, 8, 6);      // Caps lock -> Shift lock
			8'h0e: single_key(hit_mask, set_mask, 8, 2);      // Backtick -> Stop
			8'h4a: single_key(hit_mask, set_mask, 3, 6);      // /
			8'h52: single_key(hit_mask, set_mask, 2, 6);      // @
			8'h54: single_key(hit_mask, set_mask, 3, 2);      // [
			8'h5b: single_key(hit_mask, set_mask, 2, 1);      // ]
			8'h4c: single_key(hit_mask, set_mask, 3, 5);      // ;
			8'h4e: single_key(hit_mask, set_mask, 3, 1);      // -
			8'h55: single_key(hit_mask, set_mask, 3, 0);      // =
			default: ;                                        // Unmapped codes give empty masks
		endcase
	end

	// Masks stay clear of the joystick and flag bits
	a_set_within_hit: assert final ((set_mask & ~hit_mask) == '0 &&
		hit_mask[`PCW_ROWS-1:`ROW_JOY2] == '0 && hit_mask[`ROW_JOY1][5:0] == '0);

endmodule

// ==== rtl/key_matrix.sv ====
// PCW key matrix registers
// Applies masked key updates on strobe and refreshes the joystick rows and
// the link, caps-lock and update flag bits every cycle
`timescale 1ns/10ps
`include "pcw_kbd_config.svh"

module key_matrix import pcw_kbd_pkg::*; (
	input  logic        clk_sys,
	input  logic        reset,
	input  logic        strobe,
	input  logic        pressed,
	input  key_matrix_t hit_mask,
	input  key_matrix_t set_mask,
	input  logic        capslock,
	input  logic [7:0]  joy0,
	input  logic [7:0]  joy1,
	input  logic        lk1,
	input  logic        lk2,
	input  logic        lk3,
	output key_matrix_t rows
);

	joy_mouse_row_u joy_a;              // Joystick 1 row image
	joy_mouse_row_u joy_b;              // Joystick 2 row image

	// Host joystick bits into PCW order
	function automatic joy_mouse_row_u joy_row(input logic [7:0] j);
		joy_row           = '0;
		joy_row.joy.fire2 = j[5];
		joy_row.joy.fire1 = j[4];
		joy_row.joy.right = j[0];
		joy_row.joy.left  = j[1];
		joy_row.joy.down  = j[2];
		joy_row.joy.up    = j[3];
	endfunction

	assign joy_a = joy_row(joy0);
	assign joy_b = joy_row(joy1);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			rows <= '0;
		end else begin
			if (strobe)
				rows <= (rows & ~hit_mask) |
					(set_mask & {(`PCW_ROWS * `PCW_ROW_BITS){pressed}});
			// Live bits win over key writes
			rows[`ROW_JOY1][5:0]    <= joy_a[5:0];
			rows[`ROW_JOY2][5:0]    <= joy_b[5:0];
			rows[`ROW_FLAGS_D][7:6] <= {~lk2, capslock};
			rows[`ROW_FLAGS_E][7:6] <= {lk3, lk1};
			rows[`ROW_FLAGS_F][7:6] <= {1'b1, strobe};     // Transmit and update flags
		end
	end

	// Rows 12 to 15 hold nothing but their flag bits
	a_flag_rows: assert property (@(posedge clk_sys) !reset |=>
		rows[`ROW_FLAGS_F][7] && rows[4'd12] == '0 && rows[`ROW_FLAGS_D][5:0] == '0 &&
		rows[`ROW_FLAGS_E][5:0] == '0 && rows[`ROW_FLAGS_F][5:0] == '0);

endmodule

// ==== rtl/keymouse_tracker.sv ====
// Keymouse position tracker
// Each toggle of mouse_pulse is one sample. The delta magnitude is scaled
// down and added to or taken from a wrapping 7-bit position
`timescale 1ns/10ps
`include "pcw_kbd_config.svh"

module keymouse_tracker (
	input  logic                    clk_sys,
	input  logic                    reset,
	input  logic signed [8:0]       mouse_x,        // Bit 8 is the sign
	input  logic signed [8:0]       mouse_y,
	input  logic                    mouse_pulse,    // Toggles per sample
	output logic [`MOUSE_POS_W-1:0] x_pos,
	output logic [`MOUSE_POS_W-1:0] y_pos
);

	logic                    prev_pulse;
	logic                    sample_pend;           // Step latched, apply next edge
	logic [`MOUSE_POS_W-1:0] mag_x, mag_y;
	logic [`MOUSE_POS_W-1:0] step_x, step_y;
	logic                    neg_x, neg_y;

	assign mag_x = mouse_x[8] ? `MOUSE_POS_W'(~mouse_x[6:0] + 7'd1) : mouse_x[6:0];
	assign mag_y = mouse_y[8] ? `MOUSE_POS_W'(~mouse_y[6:0] + 7'd1) : mouse_y[6:0];

	always_ff @(posedge clk_sys) begin
		prev_pulse <= mouse_pulse;
		if (mouse_pulse != prev_pulse) begin
			step_x <= mag_x >> `MOUSE_SHIFT;
			step_y <= mag_y >> `MOUSE_SHIFT;
			neg_x  <= mouse_x[8];
			neg_y  <= mouse_y[8];
		end
		if (reset) begin
			sample_pend <= 1'b0;
			x_pos       <= '0;
			y_pos       <= '0;
		end else begin
			sample_pend <= mouse_pulse != prev_pulse;
			if (sample_pend) begin
				x_pos <= neg_x ? x_pos - step_x : x_pos + step_x;  // Wraps mod 128
				y_pos <= neg_y ? y_pos - step_y : y_pos + step_y;
			end
		end
	end

endmodule

// ==== rtl/matrix_read_mux.sv ====
// CPU read path for the key matrix
// Returns the addressed row; in keymouse mode rows 11 to 14 carry the
// mouse position and buttons in place of some matrix bits
`timescale 1ns/10ps
`include "pcw_kbd_config.svh"

module matrix_read_mux import pcw_kbd_pkg::*; (
	input  logic [`PCW_ADDR_W-1:0]  addr,
	input  logic                    keymouse,
	input  key_matrix_t             rows,
	input  logic                    mouse_left,
	input  logic                    mouse_middle,
	input  logic                    mouse_right,
	input  logic [`MOUSE_POS_W-1:0] x_pos,
	input  logic [`MOUSE_POS_W-1:0] y_pos,
	output matrix_row_t             key_data
);

	joy_mouse_row_u joy2;               // Row 11, joystick or mouse X

	always_comb begin
		joy2     = rows[`ROW_JOY2];
		key_data = rows[addr];
		if (keymouse) begin
			joy2.mouse.middle = mouse_middle;
			joy2.mouse.x_pos  = x_pos;
		end
		case (addr)
			`ROW_JOY2:
				key_data = joy2;
			4'd12:                                      // Top of Y
				if (keymouse) key_data = {y_pos[6:5], rows[12][5:0]};
			`ROW_FLAGS_D:                               // Flags stay, low Y below
				if (keymouse) key_data = {rows[`ROW_FLAGS_D][7:5], y_pos[4:0]};
			`ROW_FLAGS_E:
				if (keymouse) key_data = {mouse_left, mouse_right, rows[`ROW_FLAGS_E][5:0]};
			default: ;
		endcase
	end

endmodule

// ==== rtl/pcw_keyboard.sv ====
// PCW keyboard, joystick and keymouse interface, top level
// Takes host PS/2 key words, joystick and mouse samples and presents the
// 16-row key matrix to the CPU one row at a time through addr
`timescale 1ns/10ps
`include "pcw_kbd_config.svh"

module pcw_keyboard import pcw_kbd_pkg::*; (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic [10:0]            ps2_key,       // Code, ext, pressed, toggle
	input  logic [7:0]             joy0,
	input  logic [7:0]             joy1,
	input  logic                   keymouse,      // Mouse overlay on rows 11-14
	input  logic                   mouse_left,
	input  logic                   mouse_middle,
	input  logic                   mouse_right,
	input  logic signed [8:0]      mouse_x,
	input  logic signed [8:0]      mouse_y,
	input  logic                   mouse_pulse,
	input  logic                   lk1,           // Motherboard links
	input  logic                   lk2,
	input  logic                   lk3,
	input  logic [`PCW_ADDR_W-1:0] addr,
	output matrix_row_t            key_data
);

	logic                    strobe;
	logic                    pressed;
	logic                    extended;
	logic [7:0]              code;
	logic                    shift_state;
	logic                    capslock;
	key_matrix_t             hit_mask;
	key_matrix_t             set_mask;
	key_matrix_t             rows;
	logic [`MOUSE_POS_W-1:0] x_pos;
	logic [`MOUSE_POS_W-1:0] y_pos;

	key_event_ctrl   u_event   (.*);      // Event capture, modifiers
	scancode_mapper  u_mapper  (.*);      // Scancode to masks
	key_matrix       u_matrix  (.*);      // Matrix state
	keymouse_tracker u_mouse   (.*);      // Mouse positions
	matrix_read_mux  u_readmux (.*);      // CPU read path

endmodule

// ==== testbench/tb_pcw_keyboard.sv ====
// Self-checking testbench for the PCW keyboard interface
// Replays the operations of the pattern file against the DUT and compares
// every matrix read with the expected row value given in the file
`timescale 1ns/10ps

module tb_pcw_keyboard;

	localparam string pattern_file = "testbench/pcw_keyboard_patterns.txt";

	logic              clk_sys;
	logic              reset;
	logic [10:0]       ps2_key;
	logic [7:0]        joy0;
	logic [7:0]        joy1;
	logic              keymouse;
	logic              mouse_left;
	logic              mouse_middle;
	logic              mouse_right;
	logic signed [8:0] mouse_x;
	logic signed [8:0] mouse_y;
	logic              mouse_pulse;
	logic              lk1;
	logic              lk2;
	logic              lk3;
	logic [3:0]        addr;
	logic [7:0]        key_data;

	int          fd;
	int          line_total;            // Sizes the watchdog
	int          cur_test;
	int          test_num;
	int          test_errs;             // Errors in the running test
	int          pass_count;
	int          fail_count;
	string       line;
	string       op;
	logic [15:0] opa, opb, opc;         // Operand columns

	pcw_keyboard DUT (.*);

	always #4 clk_sys = ~clk_sys;       // 8 ns period

	// Realign to 1 ns after the n-th rising edge
	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clk_sys);
		#1;
	endtask

	task automatic check_value(input logic [7:0] actual, input logic [7:0] expected,
			input string msg);
		if (actual !== expected) begin
			$display("CHECK FAILED at %0t: %s, got %h expected %h", $time, msg, actual,
				expected);
			fail_count++;
			test_errs++;
		end else begin
			pass_count++;
		end
	endtask

	task automatic report_test();
		$display("test %0d finished with %0d errors", cur_test, test_errs);
		test_errs = 0;
	endtask

	task automatic count_lines();
		int cfd;
		cfd = $fopen(pattern_file, "r");
		if (cfd != 0) begin
			while ($fgets(line, cfd) != 0)
				line_total++;
			$fclose(cfd);
		end
	endtask

	// One pattern operation, operands already parsed
	task automatic run_op();
		if (op == "key") begin
			ps2_key = {~ps2_key[10], opa[0], opb[0], opc[7:0]};     // Toggle marks the event
			wait_cycles(4);
		end else if (op == "joy") begin
			joy0 = opa[7:0];
			joy1 = opb[7:0];
			wait_cycles(2);
		end else if (op == "mouse") begin
			mouse_x     = opa[8:0];
			mouse_y     = opb[8:0];
			mouse_pulse = ~mouse_pulse;     // One sample
			wait_cycles(4);
		end else if (op == "mode") begin
			keymouse = opa[0];
			{mouse_left, mouse_middle, mouse_right} = opb[2:0];
			wait_cycles(1);
		end else if (op == "link") begin
			{lk1, lk2, lk3} = {opa[0], opb[0], opc[0]};
			wait_cycles(2);
		end else if (op == "read") begin
			addr = opa[3:0];
			#6;                             // 1 ns before the next edge
			check_value(key_data, opb[7:0], $sformatf("test %0d row %0d", cur_test, addr));
			wait_cycles(1);
		end else begin
			$display("unknown operation %s in test %0d", op, test_num);
			fail_count++;
			test_errs++;
		end
	endtask

	task automatic run_patterns();
		repeat (5) @(posedge clk_sys);
		#1 reset = 1'b0;
		wait_cycles(2);
		while ($fgets(line, fd) != 0) begin
			if (line.len() < 2 || line.getc(0) == "#")
				continue;                   // Blank or comment
			if ($sscanf(line, "%d %s %h %h %h", test_num, op, opa, opb, opc) != 5) begin
				$display("pattern line could not be read: %s", line);
				fail_count++;
				test_errs++;
				continue;
			end
			if (test_num != cur_test) begin
				if (cur_test != 0)
					report_test();
				cur_test = test_num;
			end
			run_op();
		end
		$fclose(fd);
		if (cur_test != 0)
			report_test();
		$display("checks passed: %0d, checks failed: %0d", pass_count, fail_count);
		if (fail_count == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	endtask

	initial begin
		clk_sys      = 1'b0;
		reset        = 1'b1;
		ps2_key      = '0;
		joy0         = '0;
		joy1         = '0;
		keymouse     = 1'b0;
		{mouse_left, mouse_middle, mouse_right} = 3'b000;
		mouse_x      = '0;
		mouse_y      = '0;
		mouse_pulse  = 1'b0;
		{lk1, lk2, lk3} = 3'b000;
		addr         = '0;
		line_total   = 0;
		cur_test     = 0;
		test_errs    = 0;
		pass_count   = 0;
		fail_count   = 0;
		count_lines();
		fd = $fopen(pattern_file, "r");
		if (fd == 0) begin
			$display("pattern file %s could not be opened", pattern_file);
			$display("test failed");
			$finish;
		end else begin
			run_patterns();
		end
	end

	// Watchdog, ten cycles per pattern line plus reset
	initial begin
		wait (line_total > 0);
		repeat (line_total * 10 + 5) @(posedge clk_sys);
		$display("timeout, pattern run did not end within %0d cycles", line_total * 10 + 5);
		$display("test failed");
		$finish;
	end

endmodule

// ==== testbench/pcw_keyboard_patterns.txt ====
# columns: test(dec) op a b c, operands hex. key: pressed ext code, joy: joy0 joy1,
# mouse: x y (9 bit), mode: keymouse {left,middle,right}, link: lk1 lk2 lk3, read: addr expected
1 key 1 0 1c
1 read 8 20 0
1 key 1 0 3a
1 read 4 40 0
1 key 1 0 2e
1 read 6 02 0
1 key 0 0 1c
1 read 8 00 0
1 key 0 0 3a
1 read 4 00 0
1 key 0 0 2e
1 read 6 00 0
2 key 1 1 70
2 read 1 04 0
2 read 0 00 0
2 key 1 0 70
2 read 0 02 0
2 read 1 00 0
2 key 0 0 70
2 read 0 00 0
3 key 1 0 41
3 read 4 80 0
3 key 0 0 41
3 key 1 0 12
3 read 2 20 0
3 key 1 0 41
3 read 3 10 0
3 read 4 00 0
3 key 0 0 41
3 key 0 0 12
3 read 3 00 0
3 read 2 00 0
3 key 1 0 58
3 read d c0 0
3 read 8 40 0
3 key 0 0 58
3 read d c0 0
3 key 1 0 58
3 read d 80 0
3 key 0 0 58
3 read 8 00 0
4 joy d5 2a 0
4 read 9 1a 0
4 read b 25 0
4 read c 00 0
4 read f 80 0
4 link 1 1 0
4 read d 00 0
4 read e 40 0
4 link 0 0 1
4 read d 80 0
4 read e 80 0
5 mode 1 0 0
5 read b 00 0
5 read c 00 0
5 read d 80 0
5 read e 00 0
5 mouse 028 000 0
5 read b 05 0
5 mouse 1f0 000 0
5 read b 03 0
5 mouse 000 1f8 0
5 read b 03 0
5 read c c0 0
5 read d 9f 0
5 mode 1 5 0
5 read b 03 0
5 read e c0 0
5 mode 1 2 0
5 read b 83 0
5 read e 00 0
5 mode 0 0 0
5 read b 25 0
5 read e 80 0
5 read c 00 0

// ==== pcw_keyboard.f ====
+incdir+include
rtl/pcw_kbd_pkg.sv
rtl/key_event_ctrl.sv
rtl/scancode_mapper.sv
rtl/key_matrix.sv
rtl/keymouse_tracker.sv
rtl/matrix_read_mux.sv
rtl/pcw_keyboard.sv
testbench/tb_pcw_keyboard.sv

// ==== Bender.yml ====
package:
  name: pcw_keyboard

sources:
  - include_dirs:
      - include
    files:
      - rtl/pcw_kbd_pkg.sv
      - rtl/key_event_ctrl.sv
      - rtl/scancode_mapper.sv
      - rtl/key_matrix.sv
      - rtl/keymouse_tracker.sv
      - rtl/matrix_read_mux.sv
      - rtl/pcw_keyboard.sv
  - target: test
    files:
      - testbench/tb_pcw_keyboard.sv
